// ==== hw/connect4_consts.svh ====
`ifndef CONNECT4_CONSTS_SVH
`define CONNECT4_CONSTS_SVH

// Board size and index widths
`define BOARD_COLS 7
`define BOARD_ROWS 7
`define COL_W 3
`define CELL_W 6
`define HEIGHT_W 3
`define WIN_LEN 4

// Counter widths reported in the status word
`define MOVES_W 6
`define ILLEGAL_W 8

// Drawn block geometry and pixel stream
`define BLOCK_W 4
`define BLOCK_H 4
`define PIX_X_W 8
`define PIX_Y_W 7
`define COLOUR_W 3
`define COLOUR_RED 3'b100
`define COLOUR_YELLOW 3'b001

// Wishbone widths, word addresses and commands
`define WB_ADR_W 2
`define WB_DAT_W 8
`define WB_RDAT_W 32
`define ADDR_MOVE 2'd0
`define ADDR_CMD 2'd1
`define ADDR_STATUS 2'd2
`define CMD_NEW_GAME 8'd1

`endif

// ==== hw/game_pkg.sv ====
`default_nettype none

`include "connect4_consts.svh"

package game_pkg;

	// Cell contents, also used for the winner
	typedef enum logic [1:0] {
		NONE   = 2'b00,
		RED    = 2'b01,
		YELLOW = 2'b10
	} player_t;

	// One piece dropped into the board
	typedef struct packed {
		logic                  valid;
		logic [`COL_W-1:0]     col;
		logic [`HEIGHT_W-1:0]  row;
		player_t               player;
	} placement_t;

	// Cell index is row * columns + column, row 0 at the bottom
	typedef player_t [`BOARD_COLS*`BOARD_ROWS-1:0] board_t;

	function automatic logic [`CELL_W-1:0] cell_index(
		input logic [`COL_W-1:0]    col,
		input logic [`HEIGHT_W-1:0] row
	);
		return `CELL_W'(row * `BOARD_COLS + col);
	endfunction

endpackage

`default_nettype wire

// ==== hw/bus_pkg.sv ====
`default_nettype none

`include "connect4_consts.svh"

package bus_pkg;

	// Master to slave
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`WB_ADR_W-1:0]  adr;
		logic [`WB_DAT_W-1:0]  dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic                  ack;
		logic [`WB_RDAT_W-1:0] dat;
	} wb_rsp_t;

	// Word read back from ADDR_STATUS, winner in the low bits
	typedef struct packed {
		logic [`WB_RDAT_W-`MOVES_W-`ILLEGAL_W-7:0] pad;
		logic [`ILLEGAL_W-1:0] illegal;
		logic [`MOVES_W-1:0]   moves;
		logic                  game_over;
		logic                  painting;
		logic [1:0]            turn;
		logic [1:0]            winner;
	} status_t;

endpackage

`default_nettype wire

// ==== hw/wb_move_port.sv ====
`default_nettype none

`include "connect4_consts.svh"

module wb_move_port (
	input  logic                  clock,
	input  logic                  reset_n,
	input  bus_pkg::wb_req_t      wb_req,
	output bus_pkg::wb_rsp_t      wb_rsp,
	input  logic                  painting,
	input  game_pkg::player_t     winner,
	input  game_pkg::player_t     turn,
	input  logic [`MOVES_W-1:0]   moves,
	input  logic [`ILLEGAL_W-1:0] illegal,
	output logic                  move_req,
	output logic [`COL_W-1:0]     move_col,
	output logic                  new_game
);
	import game_pkg::*;
	import bus_pkg::*;

	logic    ack_q;
	logic    rd_status_q;
	logic    hit;
	logic    is_move;
	logic    is_cmd;
	logic    is_status;
	logic    accept;
	status_t status;

	////////////////////////////////////////
	// Bus decode
	////////////////////////////////////////

	// Ignore the cycle that is already being acknowledged
	assign hit       = wb_req.cyc && wb_req.stb && !ack_q;
	assign is_move   = wb_req.we && (wb_req.adr == `ADDR_MOVE);
	assign is_cmd    = wb_req.we && (wb_req.adr == `ADDR_CMD);
	assign is_status = !wb_req.we && (wb_req.adr == `ADDR_STATUS);

	// Moves wait while a block is still going out
	assign accept = hit && !(is_move && painting);

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			ack_q       <= 1'b0;
			rd_status_q <= 1'b0;
			move_req    <= 1'b0;
			new_game    <= 1'b0;
		end else begin
			ack_q       <= accept;
			rd_status_q <= accept && is_status;
			move_req    <= accept && is_move;
			new_game    <= accept && is_cmd && (wb_req.dat == `CMD_NEW_GAME);
		end
	end

	// Out of range columns saturate to 7 so they get rejected
	always_ff @(posedge clock) begin
		if (accept && is_move) begin
			if (wb_req.dat >= `BOARD_COLS)
				move_col <= `COL_W'(`BOARD_COLS);
			else
				move_col <= wb_req.dat[`COL_W-1:0];
		end
	end

	////////////////////////////////////////
	// Status word
	////////////////////////////////////////

	always_comb begin
		status           = '0;
		status.winner    = winner;
		status.turn      = turn;
		status.painting  = painting;
		status.game_over = (winner != NONE);
		status.moves     = moves;
		status.illegal   = illegal;
	end

	// Sampled in the ack cycle so the counts are already current
	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = rd_status_q ? status : '0;
	end

	a_ack_single: assert property (@(posedge clock) disable iff (!reset_n)
		wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

// ==== hw/board_store.sv ====
`default_nettype none

`include "connect4_consts.svh"

module board_store (
	input  logic                  clock,
	input  logic                  reset_n,
	input  logic                  move_req,
	input  logic [`COL_W-1:0]     move_col,
	input  logic                  new_game,
	input  logic                  game_over,
	output game_pkg::placement_t  placement,
	output game_pkg::board_t      board,
	output game_pkg::player_t     turn,
	output logic [`MOVES_W-1:0]   moves,
	output logic [`ILLEGAL_W-1:0] illegal
);
	import game_pkg::*;

	logic [`BOARD_COLS-1:0][`HEIGHT_W-1:0] heights;
	logic [`HEIGHT_W-1:0] sel_height;
	logic [`CELL_W-1:0]   target;
	logic                 col_ok;
	logic                 legal;
	logic                 reject;

	////////////////////////////////////////
	// Legality
	////////////////////////////////////////

	always_comb begin
		col_ok = (move_col < `BOARD_COLS);
		// Height of the chosen column is the lowest empty row
		sel_height = col_ok ? heights[move_col] : '0;
		legal = col_ok && (sel_height < `BOARD_ROWS) && !game_over;
		target = cell_index(move_col, sel_height);
	end

	////////////////////////////////////////
	// Cells, heights, turn and counts
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset_n || new_game) begin
			board     <= '{default: NONE};
			heights   <= '0;
			turn      <= RED;
			moves     <= '0;
			illegal   <= '0;
			placement <= '0;
			reject    <= 1'b0;
		end else begin
			placement.valid <= move_req && legal;
			reject          <= move_req && !legal;

			if (move_req) begin
				placement.col    <= move_col;
				placement.row    <= sel_height;
				placement.player <= turn;
			end

			if (move_req && legal) begin
				board[target]     <= turn;
				heights[move_col] <= sel_height + 1'b1;
				turn              <= (turn == RED) ? YELLOW : RED;
				moves             <= moves + 1'b1;
			end

			// Counted one cycle after the decision
			if (reject)
				illegal <= illegal + 1'b1;
		end
	end

	// Heights and cells must agree, so the target is always empty
	a_target_empty: assert property (@(posedge clock) disable iff (!reset_n)
		move_req && legal |-> board[target] == NONE);

endmodule

`default_nettype wire

// ==== hw/win_scan.sv ====
`default_nettype none

`include "connect4_consts.svh"

module win_scan (
	input  logic                 clock,
	input  logic                 reset_n,
	input  logic                 new_game,
	input  game_pkg::placement_t placement,
	input  game_pkg::board_t     board,
	output game_pkg::player_t    winner,
	output logic                 game_over
);
	import game_pkg::*;

	// Horizontal, vertical, rising and falling diagonal
	localparam int DIRS = 4;
	localparam int STEP_C [DIRS] = '{1, 0, 1, 1};
	localparam int STEP_R [DIRS] = '{0, 1, 1, -1};

	logic [2:0] run [DIRS];
	logic       hit;

	// Same-player cells next to the placed one, in one direction only
	function automatic int ray(input board_t b, input int col, input int row,
		input int dc, input int dr, input player_t p);
		int   c;
		int   r;
		int   n;
		logic open;
		c    = col;
		r    = row;
		n    = 0;
		open = 1'b1;
		for (int k = 1; k < `WIN_LEN; k++) begin
			c = c + dc;
			r = r + dr;
			if (c < 0 || c >= `BOARD_COLS || r < 0 || r >= `BOARD_ROWS)
				open = 1'b0;
			else if (b[cell_index(`COL_W'(c), `HEIGHT_W'(r))] != p)
				open = 1'b0;
			if (open)
				n = n + 1;
		end
		return n;
	endfunction

	// Board already holds the new piece when placement is valid
	always_comb begin
		hit = 1'b0;
		for (int d = 0; d < DIRS; d++) begin
			run[d] = 3'(1
				+ ray(board, int'(placement.col), int'(placement.row),
					STEP_C[d], STEP_R[d], placement.player)
				+ ray(board, int'(placement.col), int'(placement.row),
					-STEP_C[d], -STEP_R[d], placement.player));
			if (run[d] >= `WIN_LEN)
				hit = 1'b1;
		end
	end

	// First winner holds until a new game
	always_ff @(posedge clock) begin
		if (!reset_n || new_game)
			winner <= NONE;
		else if (placement.valid && hit && (winner == NONE))
			winner <= placement.player;
	end

	assign game_over = (winner != NONE);

endmodule

`default_nettype wire

// ==== hw/cell_painter.sv ====
`default_nettype none

`include "connect4_consts.svh"

module cell_painter (
	input  logic                 clock,
	input  logic                 reset_n,
	input  game_pkg::placement_t placement,
	input  logic                 pix_ready,
	output logic                 pix_valid,
	output logic [`PIX_X_W-1:0]  pix_x,
	output logic [`PIX_Y_W-1:0]  pix_y,
	output logic [`COLOUR_W-1:0] pix_colour,
	output logic                 painting
);
	import game_pkg::*;

	logic                 busy;
	logic [1:0]           off_x;
	logic [1:0]           off_y;
	logic                 last_x;
	logic                 last_y;
	logic [`PIX_X_W-1:0]  org_x;
	logic [`PIX_Y_W-1:0]  org_y;
	logic [`COLOUR_W-1:0] colour;

	assign last_x = (off_x == 2'(`BLOCK_W - 1));
	assign last_y = (off_y == 2'(`BLOCK_H - 1));

	// Raster walk over the block, one step per accepted pixel
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			busy  <= 1'b0;
			off_x <= '0;
			off_y <= '0;
		end else if (placement.valid) begin
			busy  <= 1'b1;
			off_x <= '0;
			off_y <= '0;
		end else if (busy && pix_ready) begin
			if (last_x) begin
				off_x <= '0;
				off_y <= off_y + 1'b1;
				if (last_y)
					busy <= 1'b0;
			end else begin
				off_x <= off_x + 1'b1;
			end
		end
	end

	// Row 0 is drawn at the bottom of the screen
	always_ff @(posedge clock) begin
		if (placement.valid) begin
			org_x  <= `PIX_X_W'(placement.col * `BLOCK_W);
			org_y  <= `PIX_Y_W'((`BOARD_ROWS - 1 - placement.row) * `BLOCK_H);
			colour <= (placement.player == RED) ? `COLOUR_RED : `COLOUR_YELLOW;
		end
	end

	assign pix_valid  = busy;
	assign pix_x      = org_x + `PIX_X_W'(off_x);
	assign pix_y      = org_y + `PIX_Y_W'(off_y);
	assign pix_colour = colour;

	// Covers the placement cycle too, before busy rises
	assign painting = busy || placement.valid;

	a_stall_stable: assert property (@(posedge clock) disable iff (!reset_n)
		pix_valid && !pix_ready |=> pix_valid && $stable({pix_x, pix_y, pix_colour}));

endmodule

`default_nettype wire

// ==== hw/connect4_top.sv ====
`default_nettype none

`include "connect4_consts.svh"

module connect4_top (
	input  logic                 clock,
	input  logic                 reset_n,
	input  bus_pkg::wb_req_t     wb_req,
	output bus_pkg::wb_rsp_t     wb_rsp,
	input  logic                 pix_ready,
	output logic                 pix_valid,
	output logic [`PIX_X_W-1:0]  pix_x,
	output logic [`PIX_Y_W-1:0]  pix_y,
	output logic [`COLOUR_W-1:0] pix_colour
);
	import game_pkg::*;

	logic                  move_req;
	logic [`COL_W-1:0]     move_col;
	logic                  new_game;
	logic                  game_over;
	logic                  painting;
	logic [`MOVES_W-1:0]   moves;
	logic [`ILLEGAL_W-1:0] illegal;
	player_t               winner;
	player_t               turn;
	placement_t            placement;
	board_t                board;

	wb_move_port port (
		.clock    (clock),
		.reset_n  (reset_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.painting (painting),
		.winner   (winner),
		.turn     (turn),
		.moves    (moves),
		.illegal  (illegal),
		.move_req (move_req),
		.move_col (move_col),
		.new_game (new_game)
	);

	board_store store (
		.clock     (clock),
		.reset_n   (reset_n),
		.move_req  (move_req),
		.move_col  (move_col),
		.new_game  (new_game),
		.game_over (game_over),
		.placement (placement),
		.board     (board),
		.turn      (turn),
		.moves     (moves),
		.illegal   (illegal)
	);

	// Checker and painter both start on the same placement
	win_scan scan (
		.clock     (clock),
		.reset_n   (reset_n),
		.new_game  (new_game),
		.placement (placement),
		.board     (board),
		.winner    (winner),
		.game_over (game_over)
	);

	cell_painter painter (
		.clock      (clock),
		.reset_n    (reset_n),
		.placement  (placement),
		.pix_ready  (pix_ready),
		.pix_valid  (pix_valid),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_colour (pix_colour),
		.painting   (painting)
	);

endmodule

`default_nettype wire

// ==== tb/connect4_tb.sv ====
`default_nettype none

`include "connect4_consts.svh"

module connect4_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 400;
	localparam int BLOCK_PIX = `BLOCK_W * `BLOCK_H;

	logic                 clock;
	logic                 reset_n;
	wb_req_t              wb_req;
	wb_rsp_t              wb_rsp;
	logic                 pix_ready;
	logic                 pix_valid;
	logic [`PIX_X_W-1:0]  pix_x;
	logic [`PIX_Y_W-1:0]  pix_y;
	logic [`COLOUR_W-1:0] pix_colour;

	int status_errors;
	int pixel_errors;
	int timeouts;
	logic [15:0] lfsr;
	int seen_x[$];
	int seen_y[$];
	int seen_c[$];
	int heights[`BOARD_COLS];

	connect4_top UUT (
		.clock      (clock),
		.reset_n    (reset_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.pix_ready  (pix_ready),
		.pix_valid  (pix_valid),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_colour (pix_colour)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// Random stalls on the pixel stream
	always @(posedge clock) begin
		lfsr = lfsr_step(lfsr);
		pix_ready <= lfsr[0];
	end

	// Accepted pixels collected away from the clock edge
	always @(negedge clock) begin
		if (reset_n && pix_valid && pix_ready) begin
			seen_x.push_back(int'(pix_x));
			seen_y.push_back(int'(pix_y));
			seen_c.push_back(int'(pix_colour));
		end
	end

	////////////////////////////////////////
	// Bus and pixel tasks
	////////////////////////////////////////

	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] dat,
		output logic [31:0] rdat);
		int n;
		n    = 0;
		rdat = '0;
		@(posedge clock);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we  <= we;
		wb_req.adr <= adr;
		wb_req.dat <= dat;
		@(negedge clock);
		while (!wb_rsp.ack && n < TIMEOUT_CYCLES) begin
			@(negedge clock);
			n++;
		end
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
		end else begin
			timeouts++;
			$display("Timeout: no bus ack for address %0d at %0t", adr, $time);
		end
		@(posedge clock);
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		wb_req.we  <= 1'b0;
	endtask

	task automatic wait_pixels(input int count);
		int n;
		n = 0;
		while (seen_x.size() < count && n < TIMEOUT_CYCLES) begin
			@(posedge clock);
			n++;
		end
		if (seen_x.size() < count) begin
			timeouts++;
			$display("Timeout: only %0d of %0d pixels arrived", seen_x.size(), count);
		end
	endtask

	// Raster order from the block origin with row 0 drawn lowest
	task automatic check_block(input int col, input int row, input int player);
		int ex;
		int ey;
		int ec;
		for (int i = 0; i < BLOCK_PIX; i++) begin
			ex = col * `BLOCK_W + i % `BLOCK_W;
			ey = (`BOARD_ROWS - 1 - row) * `BLOCK_H + i / `BLOCK_W;
			ec = (player == 1) ? `COLOUR_RED : `COLOUR_YELLOW;
			assert (seen_x[0] == ex && seen_y[0] == ey && seen_c[0] == ec) else begin
				$display("ERR %0t: pixel %0d got (%0d,%0d,%0d) expected (%0d,%0d,%0d)",
					$time, i, seen_x[0], seen_y[0], seen_c[0], ex, ey, ec);
				pixel_errors++;
			end
			void'(seen_x.pop_front());
			void'(seen_y.pop_front());
			void'(seen_c.pop_front());
		end
	endtask

	////////////////////////////////////////
	// Trace replay
	////////////////////////////////////////

	initial begin
		int fd;
		int n;
		int op;
		int arg;
		int exp_w;
		int exp_t;
		int exp_m;
		int exp_i;
		int steps;
		int prev_moves;
		int player;
		string line;
		logic [31:0] rdat;
		status_t st;

		reset_n       = 1'b0;
		wb_req        = '0;
		pix_ready     = 1'b0;
		lfsr          = 16'd18578;
		status_errors = 0;
		pixel_errors  = 0;
		timeouts      = 0;
		steps         = 0;
		prev_moves    = 0;
		player        = 1;
		foreach (heights[i])
			heights[i] = 0;

		repeat (16) @(posedge clock);
		reset_n <= 1'b1;
		@(posedge clock);

		fd = $fopen("tb/connect4_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file tb/connect4_trace.txt");
			status_errors++;
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%d %d %d %d %d %d",
					op, arg, exp_w, exp_t, exp_m, exp_i);
				if (n != 6)
					continue;
				steps++;
				if (op == 2) begin
					bus_cycle(1'b1, `ADDR_CMD, 8'(arg), rdat);
					foreach (heights[i])
						heights[i] = 0;
				end else begin
					bus_cycle(1'b1, `ADDR_MOVE, 8'(arg), rdat);
					// A legal move is one that the trace counts
					if (exp_m > prev_moves && timeouts == 0) begin
						wait_pixels(BLOCK_PIX);
						if (timeouts == 0)
							check_block(arg, heights[arg], player);
						heights[arg]++;
					end
				end
				// Every pixel has gone out, so the painter is idle here
				bus_cycle(1'b0, `ADDR_STATUS, 8'd0, rdat);
				st = rdat;
				assert (st.winner == exp_w && st.turn == exp_t && st.moves == exp_m
					&& st.illegal == exp_i && st.game_over == (exp_w != 0)
					&& st.painting == 1'b0 && st.pad == '0) else begin
					$display("ERR %0t: step %0d status %h expected w%0d t%0d m%0d i%0d",
						$time, steps, rdat, exp_w, exp_t, exp_m, exp_i);
					status_errors++;
				end
				assert (seen_x.size() == 0) else begin
					$display("ERR %0t: step %0d left %0d unexpected pixels",
						$time, steps, seen_x.size());
					pixel_errors++;
				end
				seen_x.delete();
				seen_y.delete();
				seen_c.delete();
				prev_moves = exp_m;
				player     = exp_t;
			end
			$fclose(fd);
			if (steps == 0) begin
				$display("The trace file held no steps");
				status_errors++;
			end
		end

		$display("Done: %0d steps, %0d status errors, %0d pixel errors, %0d timeouts",
			steps, status_errors, pixel_errors, timeouts);
		if (status_errors == 0 && pixel_errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== connect4.f ====
+incdir+hw
hw/game_pkg.sv
hw/bus_pkg.sv
hw/wb_move_port.sv
hw/board_store.sv
hw/win_scan.sv
hw/cell_painter.sv
hw/connect4_top.sv
tb/connect4_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Ihw
TOP      = connect4_tb
FILELIST = connect4.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Ihw --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/connect4_trace.txt ====
# op arg winner turn moves illegal  (op 1 = move to column arg, op 2 = command word arg)
# players 0 none, 1 red, 2 yellow
1 0 0 2 1 0
1 0 0 1 2 0
1 0 0 2 3 0
1 0 0 1 4 0
1 0 0 2 5 0
1 0 0 1 6 0
1 0 0 2 7 0
1 0 0 2 7 1
1 7 0 2 7 2
2 1 0 1 0 0
1 0 0 2 1 0
1 0 0 1 2 0
1 1 0 2 3 0
1 1 0 1 4 0
1 2 0 2 5 0
1 2 0 1 6 0
1 3 1 2 7 0
1 4 1 2 7 1
2 1 0 1 0 0
1 0 0 2 1 0
1 1 0 1 2 0
1 0 0 2 3 0
1 1 0 1 4 0
1 0 0 2 5 0
1 1 0 1 6 0
1 2 0 2 7 0
1 1 2 1 8 0
1 5 2 1 8 1
2 1 0 1 0 0
1 0 0 2 1 0
1 1 0 1 2 0
1 1 0 2 3 0
1 2 0 1 4 0
1 2 0 2 5 0
1 3 0 1 6 0
1 2 0 2 7 0
1 3 0 1 8 0
1 3 0 2 9 0
1 6 0 1 10 0
1 3 1 2 11 0
1 0 1 2 11 1
2 1 0 1 0 0
1 6 0 2 1 0
1 3 0 1 2 0
1 2 0 2 3 0
1 2 0 1 4 0
1 1 0 2 5 0
1 1 0 1 6 0
1 0 0 2 7 0
1 1 0 1 8 0
1 0 0 2 9 0
1 0 0 1 10 0
1 5 0 2 11 0
1 0 2 1 12 0
1 4 2 1 12 1
2 1 0 1 0 0
1 4 0 2 1 0
